//--- design/execute_stage.sv
// **************************************************
// Execute stage of the integer core
// Operand forwarding and selection, ALU and the
// writeback result register
// **************************************************

`timescale 1ns/1ps

module execute_stage
(
    input  logic              sysclk,
    input  logic              reset,
    input  logic              dec_valid,
    input  rv_pkg::reg_addr_t dec_rs1,
    input  rv_pkg::reg_addr_t dec_rs2,
    input  rv_pkg::reg_addr_t dec_rd,
    input  rv_pkg::word_t     dec_imm,
    input  logic              dec_use_imm,
    input  logic              dec_zero_a,
    input  rv_pkg::alu_op_t   dec_alu_op,
    output rv_pkg::reg_addr_t rs1_addr,
    output rv_pkg::reg_addr_t rs2_addr,
    input  rv_pkg::word_t     rs1_data,
    input  rv_pkg::word_t     rs2_data,
    output logic              wb_valid,
    output rv_pkg::reg_addr_t wb_rd,
    output rv_pkg::word_t     wb_data
);

    logic          fwd_a;
    logic          fwd_b;
    rv_pkg::word_t src_a;
    rv_pkg::word_t src_b;
    rv_pkg::word_t op_a;
    rv_pkg::word_t op_b;
    logic [4:0]    shamt;
    rv_pkg::word_t alu_result;

    // Register file is read in the same cycle
    assign rs1_addr = dec_rs1;
    assign rs2_addr = dec_rs2;

    // Result held in writeback has not reached the register file yet
    assign fwd_a = wb_valid && (wb_rd == dec_rs1);
    assign fwd_b = wb_valid && (wb_rd == dec_rs2);

    assign src_a = fwd_a ? wb_data : rs1_data;
    assign src_b = fwd_b ? wb_data : rs2_data;

    assign op_a  = dec_zero_a ? '0 : src_a;
    assign op_b  = dec_use_imm ? dec_imm : src_b;
    assign shamt = op_b[4:0];

    always_comb
    begin
        case (dec_alu_op)
            rv_pkg::ALU_ADD:
            begin
                alu_result = op_a + op_b;
            end
            rv_pkg::ALU_SUB:
            begin
                alu_result = op_a - op_b;
            end
            rv_pkg::ALU_SLL:
            begin
                alu_result = op_a << shamt;
            end
            rv_pkg::ALU_SLT:
            begin
                alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
            end
            rv_pkg::ALU_SLTU:
            begin
                alu_result = {31'b0, op_a < op_b};
            end
            rv_pkg::ALU_XOR:
            begin
                alu_result = op_a ^ op_b;
            end
            rv_pkg::ALU_SRL:
            begin
                alu_result = op_a >> shamt;
            end
            rv_pkg::ALU_SRA:
            begin
                alu_result = rv_pkg::word_t'($signed(op_a) >>> shamt);
            end
            rv_pkg::ALU_OR:
            begin
                alu_result = op_a | op_b;
            end
            rv_pkg::ALU_AND:
            begin
                alu_result = op_a & op_b;
            end
            rv_pkg::ALU_PASS_B:
            begin
                alu_result = op_b;
            end
            default:
            begin
                alu_result = '0;
            end
        endcase
    end

    always_ff @(posedge sysclk)
    begin
        if (reset)
            wb_valid <= 1'b0;
        else
            wb_valid <= dec_valid;
    end

    // Destination and result only move with a valid instruction
    always_ff @(posedge sysclk)
    begin
        if (dec_valid)
        begin
            wb_rd   <= dec_rd;
            wb_data <= alu_result;
        end
    end

endmodule

//--- design/instr_decoder.sv
// **************************************************
// Instruction decoder of the integer core
// Field split, immediate generation, ALU op mapping
// and the registered decode outputs
// **************************************************

`timescale 1ns/1ps

module instr_decoder
(
    input  logic              sysclk,
    input  logic              reset,
    input  logic              instr_valid,
    input  rv_pkg::word_t     instr,
    output logic              dec_valid,
    output rv_pkg::reg_addr_t dec_rs1,
    output rv_pkg::reg_addr_t dec_rs2,
    output rv_pkg::reg_addr_t dec_rd,
    output rv_pkg::word_t     dec_imm,
    output logic              dec_use_imm,
    output logic              dec_zero_a,
    output rv_pkg::alu_op_t   dec_alu_op
);

    logic [6:0]        opcode;
    logic [2:0]        funct3;
    logic              funct7_b5;
    rv_pkg::reg_addr_t rd_field;
    rv_pkg::word_t     imm_i;
    rv_pkg::word_t     imm_u;
    rv_pkg::word_t     imm_next;
    rv_pkg::alu_op_t   alu_op_next;
    logic              use_imm_next;
    logic              zero_a_next;
    logic              supported;

    // funct7 bit 5 selects sub only for the register form
    function automatic rv_pkg::alu_op_t arith_op(input logic [2:0] f3,
                                                 input logic f7_b5,
                                                 input logic is_reg);
        case (f3)
            rv_pkg::F3_ADD_SUB: arith_op = (is_reg && f7_b5) ? rv_pkg::ALU_SUB
                                                               : rv_pkg::ALU_ADD;
            rv_pkg::F3_SLL:     arith_op = rv_pkg::ALU_SLL;
            rv_pkg::F3_SLT:     arith_op = rv_pkg::ALU_SLT;
            rv_pkg::F3_SLTU:    arith_op = rv_pkg::ALU_SLTU;
            rv_pkg::F3_XOR:     arith_op = rv_pkg::ALU_XOR;
            rv_pkg::F3_SRL_SRA: arith_op = f7_b5 ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            rv_pkg::F3_OR:      arith_op = rv_pkg::ALU_OR;
            default:            arith_op = rv_pkg::ALU_AND;
        endcase
    endfunction

    assign opcode    = instr[6:0];
    assign rd_field  = instr[11:7];
    assign funct3    = instr[14:12];
    assign funct7_b5 = instr[30];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_u = {instr[31:12], 12'b0};

    always_comb
    begin
        supported    = 1'b1;
        use_imm_next = 1'b0;
        zero_a_next  = 1'b0;
        imm_next     = imm_i;
        alu_op_next  = rv_pkg::ALU_ADD;
        case (opcode)
            rv_pkg::OPC_OP:
            begin
                alu_op_next = arith_op(funct3, funct7_b5, 1'b1);
            end
            rv_pkg::OPC_OP_IMM:
            begin
                use_imm_next = 1'b1;
                alu_op_next  = arith_op(funct3, funct7_b5, 1'b0);
                // Shift immediates carry only shamt
                if (funct3 == rv_pkg::F3_SLL || funct3 == rv_pkg::F3_SRL_SRA)
                    imm_next = {27'b0, instr[24:20]};
            end
            rv_pkg::OPC_LUI:
            begin
                use_imm_next = 1'b1;
                zero_a_next  = 1'b1;
                imm_next     = imm_u;
                alu_op_next  = rv_pkg::ALU_PASS_B;
            end
            default:
            begin
                supported = 1'b0;
            end
        endcase
    end

    always_ff @(posedge sysclk)
    begin
        if (reset)
            dec_valid <= 1'b0;
        else
            dec_valid <= instr_valid && supported && (rd_field != '0);
    end

    always_ff @(posedge sysclk)
    begin
        if (instr_valid)
        begin
            dec_rs1     <= instr[19:15];
            dec_rs2     <= instr[24:20];
            dec_rd      <= rd_field;
            dec_imm     <= imm_next;
            dec_use_imm <= use_imm_next;
            dec_zero_a  <= zero_a_next;
            dec_alu_op  <= alu_op_next;
        end
    end

endmodule

//--- design/register_file.sv
// **************************************************
// Integer register file, 31 writable registers
// Two combinational read ports, one write port
// **************************************************

`timescale 1ns/1ps

module register_file
(
    input  logic              sysclk,
    input  logic              reset,
    input  rv_pkg::reg_addr_t rs1_addr,
    input  rv_pkg::reg_addr_t rs2_addr,
    output rv_pkg::word_t     rs1_data,
    output rv_pkg::word_t     rs2_data,
    input  logic              wb_valid,
    input  rv_pkg::reg_addr_t wb_rd,
    input  rv_pkg::word_t     wb_data
);

    // x0 has no storage
    rv_pkg::word_t regs [31:1];

    always_ff @(posedge sysclk)
    begin
        if (reset)
        begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end
        else if (wb_valid)
        begin
            regs[wb_rd] <= wb_data;
        end
    end

    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

//--- design/rv_core.sv
// **************************************************
// RV32I integer pipeline core, top level
// Decoder, execute stage and register file
// **************************************************

`timescale 1ns/1ps

module rv_core
(
    input  logic              sysclk,
    input  logic              reset,
    input  logic              instr_valid,
    input  rv_pkg::word_t     instr,
    output logic              wb_valid,
    output rv_pkg::reg_addr_t wb_rd,
    output rv_pkg::word_t     wb_data
);

    logic              dec_valid;
    rv_pkg::reg_addr_t dec_rs1;
    rv_pkg::reg_addr_t dec_rs2;
    rv_pkg::reg_addr_t dec_rd;
    rv_pkg::word_t     dec_imm;
    logic              dec_use_imm;
    logic              dec_zero_a;
    rv_pkg::alu_op_t   dec_alu_op;

    rv_pkg::reg_addr_t rs1_addr;
    rv_pkg::reg_addr_t rs2_addr;
    rv_pkg::word_t     rs1_data;
    rv_pkg::word_t     rs2_data;

    instr_decoder u_decoder
    (
        .sysclk      (sysclk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .dec_valid   (dec_valid),
        .dec_rs1     (dec_rs1),
        .dec_rs2     (dec_rs2),
        .dec_rd      (dec_rd),
        .dec_imm     (dec_imm),
        .dec_use_imm (dec_use_imm),
        .dec_zero_a  (dec_zero_a),
        .dec_alu_op  (dec_alu_op)
    );

    execute_stage u_execute
    (
        .sysclk      (sysclk),
        .reset       (reset),
        .dec_valid   (dec_valid),
        .dec_rs1     (dec_rs1),
        .dec_rs2     (dec_rs2),
        .dec_rd      (dec_rd),
        .dec_imm     (dec_imm),
        .dec_use_imm (dec_use_imm),
        .dec_zero_a  (dec_zero_a),
        .dec_alu_op  (dec_alu_op),
        .rs1_addr    (rs1_addr),
        .rs2_addr    (rs2_addr),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data)
    );

    // Writeback strobe doubles as the core output
    register_file u_regfile
    (
        .sysclk   (sysclk),
        .reset    (reset),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb_valid (wb_valid),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data)
    );

endmodule

//--- design/rv_pkg.sv
// **************************************************
// Shared types of the RV32I integer core
// Word, register-address and ALU-operation types,
// ALU operation codes, opcodes and funct3 encodings
// **************************************************

package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [3:0]  alu_op_t;

    // ALU operations
    localparam alu_op_t ALU_ADD    = 4'd0;
    localparam alu_op_t ALU_SUB    = 4'd1;
    localparam alu_op_t ALU_SLL    = 4'd2;
    localparam alu_op_t ALU_SLT    = 4'd3;
    localparam alu_op_t ALU_SLTU   = 4'd4;
    localparam alu_op_t ALU_XOR    = 4'd5;
    localparam alu_op_t ALU_SRL    = 4'd6;
    localparam alu_op_t ALU_SRA    = 4'd7;
    localparam alu_op_t ALU_OR     = 4'd8;
    localparam alu_op_t ALU_AND    = 4'd9;
    // Operand B straight through, used by lui
    localparam alu_op_t ALU_PASS_B = 4'd10;

    // Major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    // funct3 for OP and OP-IMM
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

endpackage

//--- sources.f
design/rv_pkg.sv
design/instr_decoder.sv
design/execute_stage.sv
design/register_file.sv
design/rv_core.sv
tb/rv_core_assertions.sv
tb/tb_rv_core.sv

//--- tb/rv_core_assertions.sv
// **************************************************
// Concurrent checks on the writeback strobe of rv_core
// Bound into the core from the testbench build
// **************************************************

`timescale 1ns/1ps

module rv_core_assertions
(
    input logic              sysclk,
    input logic              reset,
    input logic              instr_valid,
    input logic              wb_valid,
    input rv_pkg::reg_addr_t wb_rd
);

    int failures = 0;

    // Strobe is quiet right after reset
    assert property (@(posedge sysclk) reset |=> !wb_valid)
        else
        begin
            $error("wb_valid high in the cycle after reset");
            failures++;
        end

    // x0 is never written
    assert property (@(posedge sysclk) disable iff (reset) wb_valid |-> wb_rd != '0)
        else
        begin
            $error("writeback strobe with destination x0");
            failures++;
        end

    // Two-cycle latency from the sampling edge
    assert property (@(posedge sysclk) disable iff (reset)
                     wb_valid |-> $past(instr_valid, 2))
        else
        begin
            $error("writeback without an instruction two cycles earlier");
            failures++;
        end

endmodule

bind rv_core rv_core_assertions u_assertions
(
    .sysclk      (sysclk),
    .reset       (reset),
    .instr_valid (instr_valid),
    .wb_valid    (wb_valid),
    .wb_rd       (wb_rd)
);

//--- tb/tb_rv_core.sv
// **************************************************
// Testbench for the RV32I integer core
// Encoders, reference register model, monitor queue,
// directed tests and timeout
// **************************************************

`timescale 1ns/1ps

module tb_rv_core;

    localparam int MAX_CYCLES = 2000;

    logic              sysclk;
    logic              reset;
    logic              instr_valid;
    rv_pkg::word_t     instr;
    logic              wb_valid;
    rv_pkg::reg_addr_t wb_rd;
    rv_pkg::word_t     wb_data;

    rv_pkg::word_t     model_regs [32];
    rv_pkg::reg_addr_t exp_rd [$];
    rv_pkg::word_t     exp_data [$];
    int                exp_cycle [$];
    int                cycle;
    logic [31:0]       rng_state;
    string             test_name;

    rv_core dut
    (
        .sysclk      (sysclk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data)
    );

    initial
    begin
        sysclk = 1'b0;
        forever #10 sysclk = ~sysclk;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic compare_rd(input rv_pkg::reg_addr_t exp, input rv_pkg::reg_addr_t act);
        if (exp !== act)
            fail_run($sformatf("error: %s rd expected %0d actual %0d", test_name, exp, act));
    endtask

    task automatic compare_data(input rv_pkg::word_t exp, input rv_pkg::word_t act);
        if (exp !== act)
            fail_run($sformatf("error: %s data expected %08h actual %08h",
                               test_name, exp, act));
    endtask

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic rv_pkg::word_t enc_r(input logic [6:0] f7, input int rs2,
                                            input int rs1, input logic [2:0] f3,
                                            input int rd);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), rv_pkg::OPC_OP};
    endfunction

    function automatic rv_pkg::word_t enc_i(input logic [11:0] imm, input int rs1,
                                            input logic [2:0] f3, input int rd);
        return {imm, 5'(rs1), f3, 5'(rd), rv_pkg::OPC_OP_IMM};
    endfunction

    function automatic rv_pkg::word_t enc_u(input logic [19:0] imm, input int rd);
        return {imm, 5'(rd), rv_pkg::OPC_LUI};
    endfunction

    // Reference model: sequential RV32I semantics
    task automatic issue(input rv_pkg::word_t w);
        logic [6:0]    opc;
        logic [2:0]    f3;
        logic          alt;
        rv_pkg::word_t a;
        rv_pkg::word_t b;
        rv_pkg::word_t res;
        logic          writes;
        int            rd;
        opc    = w[6:0];
        f3     = w[14:12];
        alt    = w[30];
        rd     = w[11:7];
        a      = model_regs[w[19:15]];
        b      = (opc == rv_pkg::OPC_OP) ? model_regs[w[24:20]] : {{20{w[31]}}, w[31:20]};
        writes = (opc == rv_pkg::OPC_OP) || (opc == rv_pkg::OPC_OP_IMM)
                 || (opc == rv_pkg::OPC_LUI);
        case (f3)
            3'b000:  res = (opc == rv_pkg::OPC_OP && alt) ? a - b : a + b;
            3'b001:  res = a << b[4:0];
            3'b010:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  res = (a < b) ? 32'd1 : 32'd0;
            3'b100:  res = a ^ b;
            3'b101:  res = alt ? rv_pkg::word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  res = a | b;
            default: res = a & b;
        endcase
        if (opc == rv_pkg::OPC_LUI)
            res = {w[31:12], 12'b0};
        @(posedge sysclk);
        instr_valid <= 1'b1;
        instr       <= w;
        if (writes && rd != 0)
        begin
            model_regs[rd] = res;
            exp_rd.push_back(5'(rd));
            exp_data.push_back(res);
            exp_cycle.push_back(cycle + 2);
        end
    endtask

    task automatic idle_and_drain();
        @(posedge sysclk);
        instr_valid <= 1'b0;
        while (exp_rd.size() > 0)
            @(negedge sysclk);
        repeat (3) @(negedge sysclk);
    endtask

    task automatic load_reg(input int rd, input rv_pkg::word_t value);
        rv_pkg::word_t upper;
        upper = value + 32'h800;
        issue(enc_u(upper[31:12], rd));
        issue(enc_i(value[11:0], rd, rv_pkg::F3_ADD_SUB, rd));
    endtask

    // Outputs are sampled at the falling edge, away from driving
    always @(negedge sysclk)
    begin
        if (dut.u_assertions.failures != 0)
            fail_run("a concurrent assertion on the core failed");
        if (!reset && wb_valid === 1'b1)
        begin
            if (exp_rd.size() == 0)
                fail_run($sformatf("unexpected writeback to x%0d in %s", wb_rd, test_name));
            if (exp_cycle[0] != cycle)
                fail_run($sformatf("error: %s latency expected cycle %0d actual %0d",
                                   test_name, exp_cycle[0], cycle));
            compare_rd(exp_rd.pop_front(), wb_rd);
            compare_data(exp_data.pop_front(), wb_data);
            void'(exp_cycle.pop_front());
        end
        cycle = cycle + 1;
        if (cycle > MAX_CYCLES)
            fail_run("timeout: the run exceeded its cycle limit");
    end

    task automatic test_after_reset();
        test_name = "after_reset";
        repeat (4) @(posedge sysclk);
        issue(enc_r(7'b0, 2, 1, rv_pkg::F3_ADD_SUB, 5));
        idle_and_drain();
    endtask

    task automatic test_reg_reg();
        test_name = "reg_reg";
        for (int r = 1; r <= 4; r++)
            load_reg(r, next_random());
        load_reg(4, 32'hffff_fff0);
        for (int p = 0; p < 2; p++)
        begin
            issue(enc_r(7'h00, 2 + 2 * p, 1 + 2 * p, rv_pkg::F3_ADD_SUB, 10));
            issue(enc_r(7'h20, 2 + 2 * p, 1 + 2 * p, rv_pkg::F3_ADD_SUB, 11));
            issue(enc_r(7'h00, 2 + 2 * p, 1 + 2 * p, rv_pkg::F3_SLL, 12));
            issue(enc_r(7'h00, 2 + 2 * p, 1 + 2 * p, rv_pkg::F3_SLT, 13));
            issue(enc_r(7'h00, 2 + 2 * p, 1 + 2 * p, rv_pkg::F3_SLTU, 14));
            issue(enc_r(7'h00, 2 + 2 * p, 1 + 2 * p, rv_pkg::F3_XOR, 15));
            issue(enc_r(7'h00, 2 + 2 * p, 1 + 2 * p, rv_pkg::F3_SRL_SRA, 16));
            issue(enc_r(7'h20, 2 + 2 * p, 1 + 2 * p, rv_pkg::F3_SRL_SRA, 17));
            issue(enc_r(7'h00, 2 + 2 * p, 1 + 2 * p, rv_pkg::F3_OR, 18));
            issue(enc_r(7'h00, 2 + 2 * p, 1 + 2 * p, rv_pkg::F3_AND, 19));
        end
        idle_and_drain();
    endtask

    task automatic test_immediate();
        logic [31:0] r;
        test_name = "immediate";
        load_reg(1, 32'h8765_4321);
        for (int n = 0; n < 4; n++)
        begin
            r = next_random();
            issue(enc_i(r[11:0], 1, rv_pkg::F3_ADD_SUB, 20));
            issue(enc_i(12'hff0, 1, rv_pkg::F3_SLT, 21));
            issue(enc_i(r[23:12], 1, rv_pkg::F3_SLTU, 22));
            issue(enc_i(r[11:0] | 12'h800, 1, rv_pkg::F3_XOR, 23));
            issue(enc_i(r[23:12], 1, rv_pkg::F3_OR, 24));
            issue(enc_i(r[11:0], 1, rv_pkg::F3_AND, 25));
            issue(enc_i({7'h00, r[4:0]}, 1, rv_pkg::F3_SLL, 26));
            issue(enc_i({7'h00, r[9:5]}, 1, rv_pkg::F3_SRL_SRA, 27));
            issue(enc_i({7'h20, r[14:10]}, 1, rv_pkg::F3_SRL_SRA, 28));
            issue(enc_u(r[31:12], 29));
        end
        idle_and_drain();
    endtask

    task automatic test_forwarding();
        test_name = "forwarding";
        load_reg(6, next_random());
        load_reg(7, next_random());
        for (int n = 0; n < 6; n++)
        begin
            issue(enc_i(12'h013, 6, rv_pkg::F3_ADD_SUB, 6));
            issue(enc_r(7'h00, 6, 7, rv_pkg::F3_XOR, 7));
            issue(enc_r(7'h20, 7, 6, rv_pkg::F3_ADD_SUB, 8));
            issue(enc_r(7'h00, 6, 8, rv_pkg::F3_SLTU, 9));
            issue(enc_r(7'h00, 8, 9, rv_pkg::F3_ADD_SUB, 6));
        end
        idle_and_drain();
    endtask

    task automatic test_suppressed();
        test_name = "suppressed";
        issue(enc_i(12'h055, 1, rv_pkg::F3_ADD_SUB, 0));
        issue(enc_r(7'h00, 0, 0, rv_pkg::F3_OR, 8));
        issue(32'h0000_057f);
        issue(enc_i(12'h001, 0, rv_pkg::F3_ADD_SUB, 9));
        idle_and_drain();
    endtask

    task automatic test_throughput();
        logic [31:0] r;
        test_name = "throughput";
        for (int n = 0; n < 24; n++)
        begin
            r = next_random();
            if (r[0])
                issue(enc_r({1'b0, r[1], 5'b0}, r[12:8], r[17:13], r[4:2], r[22:18] | 5'd1));
            else
                issue(enc_i(r[31:20], r[17:13], r[4:2], r[22:18] | 5'd1));
        end
        idle_and_drain();
    endtask

    initial
    begin
        instr_valid = 1'b0;
        instr       = '0;
        reset       = 1'b1;
        cycle       = 0;
        rng_state   = 32'd6;
        test_name   = "reset";
        for (int r = 0; r < 32; r++)
            model_regs[r] = '0;
        repeat (2) @(posedge sysclk);
        reset <= 1'b0;
        test_after_reset();
        test_reg_reg();
        test_immediate();
        test_forwarding();
        test_suppressed();
        test_throughput();
        if (dut.u_assertions.failures != 0)
            fail_run("a concurrent assertion on the core failed");
        else
        begin
            $display("TEST PASSED");
            $finish;
        end
    end

endmodule
